//--- include/memSubsys_params.svh
`ifndef MEMSUBSYS_PARAMS_SVH
`define MEMSUBSYS_PARAMS_SVH

// ========================================
// Memory geometry
// ========================================
`define MEM_BYTES  4096
`define MEM_ADDR_W 12     // Byte address bits, upper AXI bits are dropped

// Access size codes on the data port
`define MW_BYTE 2'b00
`define MW_HALF 2'b01
`define MW_WORD 2'b10

// AXI response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

// Write strobes that select a size
`define STRB_BYTE 4'b0001
`define STRB_HALF 4'b0011
`define STRB_WORD 4'b1111

`endif

//--- source/memPkg.sv
`include "memSubsys_params.svh"

package memPkg;

    // ========================================
    // Vector types
    // ========================================
    typedef logic [`MEM_ADDR_W-1:0] byteAddrT;   // Byte address inside the memory
    typedef logic [31:0]            wordT;
    typedef logic [1:0]             accessSizeT; // One of the MW_* codes

    // ========================================
    // Bundles between blocks
    // ========================================

    // One request on the data port of the memory
    typedef struct packed {
        logic       write;  // High stores, low loads
        accessSizeT size;
        byteAddrT   addr;
        wordT       wdata;  // Payload sits in the low lanes
    } dataReqT;

    // Instruction word with the address it was fetched from
    typedef struct packed {
        byteAddrT addr;
        wordT     instr;
    } fetchOutT;

    // AXI slave states
    typedef enum logic [2:0] {
        idle,
        writeMem,
        writeResp,
        readMem,
        readResp
    } axiStateT;

endpackage

//--- source/byteMem.sv
`timescale 1ns/100ps
`include "memSubsys_params.svh"

module byteMem
    import memPkg::*;
(
    input  logic     clk,
    input  logic     dataEn,
    input  dataReqT  dataReq,
    output wordT     dataRdata,
    input  byteAddrT fetchAddr,
    output wordT     fetchRdata
);

    logic [7:0] mem [`MEM_BYTES];

    byteAddrT dataByte  [4];  // Consecutive byte addresses of the data access
    byteAddrT fetchByte [4];  // Same for the fetch port
    wordT     dataWord;       // Four raw bytes at the data address
    wordT     fetchWord;
    wordT     dataLoad;       // Data word trimmed to the access size

    // Memory starts out all zero
    initial begin
        for (int i = 0; i < `MEM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
    end

    // ========================================
    // Address generation
    // ========================================

    // The 12-bit sum wraps by itself at the top of the memory
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            dataByte[k]  = dataReq.addr + byteAddrT'(k);
            fetchByte[k] = fetchAddr + byteAddrT'(k);
        end
    end

    // Little endian, lowest address in the low lane
    assign dataWord  = {mem[dataByte[3]], mem[dataByte[2]],
                        mem[dataByte[1]], mem[dataByte[0]]};
    assign fetchWord = {mem[fetchByte[3]], mem[fetchByte[2]],
                        mem[fetchByte[1]], mem[fetchByte[0]]};

    // Zero-extend short loads
    always_comb begin
        case (dataReq.size)
            `MW_BYTE: dataLoad = {24'h000000, dataWord[7:0]};
            `MW_HALF: dataLoad = {16'h0000, dataWord[15:0]};
            `MW_WORD: dataLoad = dataWord;
            default:  dataLoad = '0;
        endcase
    end

    // ========================================
    // Storage
    // ========================================
    always @(posedge clk) begin
        if (dataEn && dataReq.write) begin
            case (dataReq.size)
                `MW_BYTE: begin
                    mem[dataByte[0]] <= dataReq.wdata[7:0];
                end
                `MW_HALF: begin
                    mem[dataByte[0]] <= dataReq.wdata[7:0];
                    mem[dataByte[1]] <= dataReq.wdata[15:8];
                end
                `MW_WORD: begin
                    mem[dataByte[0]] <= dataReq.wdata[7:0];
                    mem[dataByte[1]] <= dataReq.wdata[15:8];
                    mem[dataByte[2]] <= dataReq.wdata[23:16];
                    mem[dataByte[3]] <= dataReq.wdata[31:24];
                end
                default: ;  // Unknown size stores nothing
            endcase
        end
    end

    // Registered read ports, both see the array before this edge's write
    always_ff @(posedge clk) begin
        if (dataEn && !dataReq.write) begin
            dataRdata <= dataLoad;  // Held until the next load
        end
        fetchRdata <= fetchWord;    // Fetch port reads every cycle
    end

endmodule

//--- source/axiSlaveFsm.sv
`timescale 1ns/100ps
`include "memSubsys_params.svh"

module axiSlaveFsm
    import memPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    // Write address channel
    input  logic        awValid,
    output logic        awReady,
    input  logic [31:0] awAddr,
    // Write data channel
    input  logic        wValid,
    output logic        wReady,
    input  wordT        wData,
    input  logic [3:0]  wStrb,
    // Write response channel
    output logic        bValid,
    input  logic        bReady,
    output logic [1:0]  bResp,
    // Read address channel
    input  logic        arValid,
    output logic        arReady,
    input  logic [31:0] arAddr,
    // Read data channel
    output logic        rValid,
    input  logic        rReady,
    output wordT        rData,
    output logic [1:0]  rResp,
    // Data port of the memory
    output logic        dataEn,
    output dataReqT     dataReq,
    input  wordT        dataRdata
);

    axiStateT   state;
    axiStateT   nextState;
    dataReqT    req;        // Request held for the memory cycle
    logic       wrLegal;    // Held write had a legal strobe
    accessSizeT strbSize;
    logic       strbLegal;
    logic       wrAccept;
    logic       rdAccept;

    // ========================================
    // Strobe decode and handshakes
    // ========================================
    always_comb begin
        strbLegal = 1'b1;
        case (wStrb)
            `STRB_BYTE: strbSize = `MW_BYTE;
            `STRB_HALF: strbSize = `MW_HALF;
            `STRB_WORD: strbSize = `MW_WORD;
            default: begin
                strbSize  = `MW_WORD;
                strbLegal = 1'b0;  // Answered with SLVERR
            end
        endcase
    end

    // AW and W go in together, a pending write beats a read
    assign wrAccept = (state == idle) && awValid && wValid;
    assign rdAccept = (state == idle) && arValid && !(awValid && wValid);

    assign awReady = wrAccept;
    assign wReady  = wrAccept;
    assign arReady = rdAccept;

    // ========================================
    // State machine
    // ========================================
    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (wrAccept) begin
                    nextState = writeMem;
                end else if (rdAccept) begin
                    nextState = readMem;
                end
            end
            writeMem:  nextState = writeResp;
            writeResp: nextState = bReady ? idle : writeResp;
            readMem:   nextState = readResp;
            readResp:  nextState = rReady ? idle : readResp;
            default:   nextState = idle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= idle;
            wrLegal <= 1'b0;
        end else begin
            state <= nextState;
            if (wrAccept) begin
                wrLegal <= strbLegal;
            end
        end
    end

    // Capture the request, upper address bits are ignored
    always_ff @(posedge clk) begin
        if (wrAccept) begin
            req.write <= 1'b1;
            req.size  <= strbSize;
            req.addr  <= awAddr[`MEM_ADDR_W-1:0];
            req.wdata <= wData;
        end else if (rdAccept) begin
            req.write <= 1'b0;
            req.size  <= `MW_WORD;  // AXI4-Lite has no read size
            req.addr  <= arAddr[`MEM_ADDR_W-1:0];
            req.wdata <= '0;
        end
    end

    // ========================================
    // Outputs
    // ========================================
    assign dataEn  = ((state == writeMem) && wrLegal) || (state == readMem);
    assign dataReq = req;

    assign bValid = (state == writeResp);
    assign bResp  = wrLegal ? `RESP_OKAY : `RESP_SLVERR;

    // Memory keeps its registered word, no request issues until R completes
    assign rValid = (state == readResp);
    assign rData  = dataRdata;
    assign rResp  = `RESP_OKAY;

endmodule

//--- source/fetchSequencer.sv
`timescale 1ns/100ps

module fetchSequencer
    import memPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  logic     redirectValid,
    input  byteAddrT redirectAddr,
    output byteAddrT fetchAddr,
    input  wordT     fetchRdata,
    output logic     fetchValid,
    input  logic     fetchReady,
    output fetchOutT fetchOut
);

    byteAddrT pc;          // Next address to issue
    byteAddrT issuedAddr;  // Address whose word is on fetchRdata
    logic     issued;      // fetchRdata holds a live word
    logic     running;     // Set by the first redirect
    logic     stall;
    logic     advance;

    // ========================================
    // Issue control
    // ========================================
    assign stall   = issued && !fetchReady;
    assign advance = running && !stall;

    // During a stall the held address is read again, so the word stays put
    assign fetchAddr = stall ? issuedAddr : pc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc         <= '0;
            issuedAddr <= '0;
            issued     <= 1'b0;
            running    <= 1'b0;
        end else if (redirectValid) begin
            pc      <= redirectAddr;
            issued  <= 1'b0;       // Throw away the fetch in flight
            running <= 1'b1;
        end else if (advance) begin
            issuedAddr <= pc;
            pc         <= pc + byteAddrT'(4);  // Wraps at 4 KiB
            issued     <= 1'b1;
        end
    end

    // ========================================
    // Output channel
    // ========================================
    assign fetchValid     = issued;
    assign fetchOut.addr  = issuedAddr;
    assign fetchOut.instr = fetchRdata;  // Word returned for issuedAddr

endmodule

//--- source/memSubsys.sv
`timescale 1ns/100ps

module memSubsys
    import memPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    // AXI4-Lite slave
    input  logic        awValid,
    output logic        awReady,
    input  logic [31:0] awAddr,
    input  logic        wValid,
    output logic        wReady,
    input  wordT        wData,
    input  logic [3:0]  wStrb,
    output logic        bValid,
    input  logic        bReady,
    output logic [1:0]  bResp,
    input  logic        arValid,
    output logic        arReady,
    input  logic [31:0] arAddr,
    output logic        rValid,
    input  logic        rReady,
    output wordT        rData,
    output logic [1:0]  rResp,
    // Instruction stream
    input  logic        redirectValid,
    input  byteAddrT    redirectAddr,
    output logic        fetchValid,
    input  logic        fetchReady,
    output fetchOutT    fetchOut
);

    logic     dataEn;      // Data port strobe from the AXI side
    dataReqT  dataReq;
    wordT     dataRdata;
    byteAddrT fetchAddr;   // Instruction port address
    wordT     fetchRdata;

    // ========================================
    // Blocks
    // ========================================
    axiSlaveFsm axiSlaveFsm_inst (
        .clk       (clk),
        .arstN     (arstN),
        .awValid   (awValid),
        .awReady   (awReady),
        .awAddr    (awAddr),
        .wValid    (wValid),
        .wReady    (wReady),
        .wData     (wData),
        .wStrb     (wStrb),
        .bValid    (bValid),
        .bReady    (bReady),
        .bResp     (bResp),
        .arValid   (arValid),
        .arReady   (arReady),
        .arAddr    (arAddr),
        .rValid    (rValid),
        .rReady    (rReady),
        .rData     (rData),
        .rResp     (rResp),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .dataRdata (dataRdata)
    );

    fetchSequencer fetchSequencer_inst (
        .clk           (clk),
        .arstN         (arstN),
        .redirectValid (redirectValid),
        .redirectAddr  (redirectAddr),
        .fetchAddr     (fetchAddr),
        .fetchRdata    (fetchRdata),
        .fetchValid    (fetchValid),
        .fetchReady    (fetchReady),
        .fetchOut      (fetchOut)
    );

    byteMem byteMem_inst (
        .clk        (clk),
        .dataEn     (dataEn),
        .dataReq    (dataReq),
        .dataRdata  (dataRdata),
        .fetchAddr  (fetchAddr),
        .fetchRdata (fetchRdata)
    );

endmodule

//--- sim/memSubsys_chk.sv
`timescale 1ns/100ps
`include "memSubsys_params.svh"

module memSubsys_chk
    import memPkg::*;
(
    input logic       clk,
    input logic       arstN,
    input logic       awValid,
    input logic       awReady,
    input logic       wValid,
    input logic       wReady,
    input logic [3:0] wStrb,
    input logic       bValid,
    input logic       bReady,
    input logic [1:0] bResp,
    input logic       rValid,
    input logic       rReady,
    input wordT       rData,
    input logic       redirectValid,
    input logic       fetchValid,
    input logic       fetchReady,
    input fetchOutT   fetchOut
);

    logic     strbBad;   // Strobe of the write being answered was illegal
    logic     havePrev;  // A fetch was taken since the last redirect
    byteAddrT prevAddr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            strbBad  <= 1'b0;
            havePrev <= 1'b0;
            prevAddr <= '0;
        end else begin
            if (awValid && awReady && wValid && wReady) begin
                strbBad <= !(wStrb == `STRB_BYTE || wStrb == `STRB_HALF
                             || wStrb == `STRB_WORD);
            end
            if (redirectValid) begin
                havePrev <= 1'b0;  // Next fetch starts a new stream
            end else if (fetchValid && fetchReady) begin
                havePrev <= 1'b1;
                prevAddr <= fetchOut.addr;
            end
        end
    end

    // ========================================
    // Protocol properties
    // ========================================
    bHold: assert property (@(posedge clk) disable iff (!arstN)
        bValid && !bReady |=> bValid && $stable(bResp))
        else $error("write response dropped before it was accepted");

    rHold: assert property (@(posedge clk) disable iff (!arstN)
        rValid && !rReady |=> rValid && $stable(rData))
        else $error("read data dropped or changed before it was accepted");

    bRespCode: assert property (@(posedge clk) disable iff (!arstN)
        bValid |-> bResp == (strbBad ? `RESP_SLVERR : `RESP_OKAY))
        else $error("write response code does not match the write strobe");

    // A stalled instruction stays put unless a redirect flushes it
    fetchStall: assert property (@(posedge clk) disable iff (!arstN)
        fetchValid && !fetchReady && !redirectValid |=> fetchValid && $stable(fetchOut))
        else $error("instruction output changed while stalled");

    fetchStep: assert property (@(posedge clk) disable iff (!arstN)
        fetchValid && fetchReady && havePrev |-> fetchOut.addr == prevAddr + byteAddrT'(4))
        else $error("instruction address did not advance by four");

endmodule

bind memSubsys memSubsys_chk memSubsys_chk_inst (.*);

//--- sim/memSubsysTb.sv
`timescale 1ns/100ps
`include "memSubsys_params.svh"

module memSubsysTb
    import memPkg::*;
();

    localparam int Timeout = 200;  // Cycles allowed for any single wait

    logic        clk = 1'b0;
    logic        arstN;
    logic        awValid, wValid, bReady, arValid, rReady;
    logic        awReady, wReady, bValid, arReady, rValid;
    logic [31:0] awAddr, arAddr;
    wordT        wData, rData;
    logic [3:0]  wStrb;
    logic [1:0]  bResp, rResp;
    logic        redirectValid, fetchValid, fetchReady;
    byteAddrT    redirectAddr;
    fetchOutT    fetchOut;
    integer      seed = 32'hf6de;
    logic [7:0]  model [`MEM_BYTES];  // Expected memory contents

    memSubsys memSubsys_inst (.*);

    always #50 clk = ~clk;

    // ========================================
    // Checking helpers
    // ========================================
    task automatic stopOnError();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic countCycle(inout int n, input string what);
        n++;
        if (n > Timeout) begin
            $display("timeout while waiting for %s", what);
            stopOnError();
        end
    endtask

    task automatic checkValue(input string sig, input wordT expected, input wordT actual);
        assert (actual === expected) else begin
            $display("mismatch %s expected %h actual %h", sig, expected, actual);
            stopOnError();
        end
    endtask

    // Little endian word from the model, byte addresses wrap at the top
    function automatic wordT modelWord(input logic [31:0] addr);
        wordT w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = model[byteAddrT'((addr + 32'(k)) % `MEM_BYTES)];
        end
        return w;
    endfunction

    function automatic int strobeBytes(input logic [3:0] strb);
        case (strb)
            4'b0001: return 1;
            4'b0011: return 2;
            4'b1111: return 4;
            default: return 0;  // Illegal pattern stores nothing
        endcase
    endfunction

    // ========================================
    // AXI host
    // ========================================
    task automatic axiWrite(input logic [31:0] addr, input wordT data, input logic [3:0] strb);
        int         n;
        int         len;
        logic [1:0] expResp;
        n = 0;
        len = strobeBytes(strb);
        expResp = (len == 0) ? 2'b10 : 2'b00;
        @(negedge clk);
        awValid = 1'b1;
        awAddr  = addr;
        wValid  = 1'b1;
        wData   = data;
        wStrb   = strb;
        #40;  // Look just before the rising edge
        while (!(awReady && wReady)) begin
            countCycle(n, "write address and data acceptance");
            @(negedge clk);
            #40;
        end
        @(negedge clk);
        awValid = 1'b0;
        wValid  = 1'b0;
        n = 0;
        #40;
        while (!bValid) begin
            countCycle(n, "write response");
            @(negedge clk);
            #40;
        end
        checkValue("bResp", 32'(expResp), 32'(bResp));
        if (bResp == 2'b00) begin
            for (int k = 0; k < len; k++) begin
                model[byteAddrT'((addr + 32'(k)) % `MEM_BYTES)] = data[8*k +: 8];
            end
        end
        @(negedge clk);
        bReady = 1'b1;  // Response is held off for one cycle first
        @(negedge clk);
        bReady = 1'b0;
    endtask

    task automatic readAndCompare(input logic [31:0] addr);
        int n;
        n = 0;
        @(negedge clk);
        arValid = 1'b1;
        arAddr  = addr;
        #40;
        while (!arReady) begin
            countCycle(n, "read address acceptance");
            @(negedge clk);
            #40;
        end
        @(negedge clk);
        arValid = 1'b0;
        n = 0;
        #40;
        while (!rValid) begin
            countCycle(n, "read data");
            @(negedge clk);
            #40;
        end
        checkValue("rData", modelWord(addr), rData);
        checkValue("rResp", 32'h0, 32'(rResp));
        @(negedge clk);
        rReady = 1'b1;  // Read data waits a cycle before it is taken
        @(negedge clk);
        rReady = 1'b0;
    endtask

    // ========================================
    // Instruction stream
    // ========================================
    task automatic fetchStream(input byteAddrT start, input int words,
                               input int jumpAt, input byteAddrT jumpAddr);
        byteAddrT expAddr;
        int       got;
        int       n;
        expAddr = start;
        got = 0;
        n = 0;
        @(negedge clk);
        redirectValid = 1'b1;
        redirectAddr  = start;
        while (got < words) begin
            @(negedge clk);
            redirectValid = 1'b0;
            fetchReady = 1'($random(seed));  // Random back-pressure
            if (fetchValid && fetchReady) begin
                checkValue("fetchOut.addr", 32'(expAddr), 32'(fetchOut.addr));
                checkValue("fetchOut.instr", modelWord(32'(expAddr)), fetchOut.instr);
                expAddr = byteAddrT'((expAddr + 4) % `MEM_BYTES);
                got++;
                n = 0;
                if (got == jumpAt) begin
                    // Lands on the same edge that takes this word
                    redirectValid = 1'b1;
                    redirectAddr  = jumpAddr;
                    expAddr       = jumpAddr;
                end
            end else begin
                countCycle(n, "an instruction word");
            end
        end
        @(negedge clk);
        redirectValid = 1'b0;
        fetchReady    = 1'b1;  // Free run, never stalls
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        for (int i = 0; i < `MEM_BYTES; i++) begin
            model[i] = 8'h00;
        end
        arstN         = 1'b0;
        awValid       = 1'b0;
        awAddr        = '0;
        wValid        = 1'b0;
        wData         = '0;
        wStrb         = '0;
        bReady        = 1'b0;
        arValid       = 1'b0;
        arAddr        = '0;
        rReady        = 1'b0;
        redirectValid = 1'b0;
        redirectAddr  = '0;
        fetchReady    = 1'b0;

        // Reset for 8 cycles, then a few idle cycles
        for (int c = 0; c < 12; c++) begin
            @(negedge clk);
            if (c == 7) begin
                arstN = 1'b1;
            end
            assert (!(awReady || wReady || arReady || bValid || rValid || fetchValid)) else begin
                $display("a valid or ready output is high with no request pending");
                stopOnError();
            end
        end

        axiWrite(32'h0000_0100, 32'h1122_3344, 4'b1111);
        axiWrite(32'h0000_0203, 32'hA1B2_C3D4, 4'b1111);
        axiWrite(32'h0000_0301, 32'h5555_BEEF, 4'b0011);
        axiWrite(32'h0000_0402, 32'h9999_997A, 4'b0001);
        axiWrite(32'h0000_1FFE, 32'hCAFE_F00D, 4'b1111);  // Bytes FFE to 001
        axiWrite(32'hFFFF_F005, 32'h0000_0042, 4'b0001);
        readAndCompare(32'h0000_0100);
        readAndCompare(32'h0000_0203);
        readAndCompare(32'h0000_0301);
        readAndCompare(32'h0000_0402);
        readAndCompare(32'h0000_0FFE);
        readAndCompare(32'h0000_1000);
        readAndCompare(32'h0000_3005);

        // Illegal strobe leaves memory alone
        axiWrite(32'h0000_0100, 32'hDEAD_BEEF, 4'b0101);
        readAndCompare(32'h0000_0100);

        // Program words across the top of memory and in the middle
        for (int i = 0; i < 8; i++) begin
            axiWrite(32'h0000_0FF0 + 32'(4 * i), $random(seed), 4'b1111);
            axiWrite(32'h0000_0800 + 32'(4 * i), $random(seed), 4'b1111);
        end
        fetchStream(12'hFF0, 12, 0, 12'h000);
        fetchStream(12'h800, 10, 3, 12'hFF8);

        $display("No errors");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
source/memPkg.sv
source/byteMem.sv
source/axiSlaveFsm.sv
source/fetchSequencer.sv
source/memSubsys.sv
sim/memSubsys_chk.sv
sim/memSubsysTb.sv

//--- run.sh
#!/bin/sh
# Build the memSubsys testbench with Verilator, run it, then scan the log

rm -f sim.log
verilator --binary --timing --assert --top-module memSubsysTb -f src.f -o memSubsysTb \
    && ./obj_dir/memSubsysTb > sim.log 2>&1 \
    || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
